// ==== common/gemv_settings.svh ====
`ifndef GEMV_SETTINGS_SVH
`define GEMV_SETTINGS_SVH

// number of elements in one matrix row and in the vector.
`define GEMV_VEC_LEN 32

// width of one signed element.
`define GEMV_ELEM_W 6

// number of matrix rows held by the engine.
`define GEMV_ROWS 8

// width of a row address, enough to index GEMV_ROWS rows.
`define GEMV_ROW_AW 3

`endif

// ==== common/gemv_data_pkg.sv ====
`default_nettype none

`include "gemv_settings.svh"

package gemv_data_pkg;

    // one signed matrix or vector element.
    typedef logic signed [`GEMV_ELEM_W-1:0] elem_t;

    // a full row, element 0 in the lowest bits.
    typedef elem_t [`GEMV_VEC_LEN-1:0] row_t;

    // a signed product of two elements needs twice the element width.
    localparam int PROD_W = 2 * `GEMV_ELEM_W;

    typedef logic signed [PROD_W-1:0] prod_t;

    // summing VEC_LEN products adds log2(VEC_LEN) bits of growth.
    // the extreme case is 32 * (-32 * -32) = 32768, which fits in 17 signed bits.
    localparam int ACC_W = PROD_W + $clog2(`GEMV_VEC_LEN);

    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// ==== common/gemv_ctrl_pkg.sv ====
`default_nettype none

`include "gemv_settings.svh"

package gemv_ctrl_pkg;

    // unsigned index into the matrix and result stores.
    typedef logic [`GEMV_ROW_AW-1:0] row_idx_t;

    // issue streams rows into the pipeline, drain waits for the last retire,
    // finish marks completion for a single cycle.
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/row_store.sv ====
`default_nettype none

`include "gemv_settings.svh"

module row_store #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = `GEMV_ROWS
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     wr_en,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
    input  entry_t                        wr_data,
    input  wire logic                     rd_en,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
    output entry_t                        rd_data,
    output logic                          rd_valid
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data is registered, so it appears one cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

// ==== src/row_sequencer.sv ====
`default_nettype none

`include "gemv_settings.svh"

module row_sequencer (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              clear,
    input  wire logic              advance,
    output gemv_ctrl_pkg::row_idx_t row_idx,
    output logic                   last_row
);

    import gemv_ctrl_pkg::*;

    localparam row_idx_t LAST_IDX = row_idx_t'(`GEMV_ROWS - 1);

    // clear wins over advance, so a start always begins at row 0.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_idx <= '0;
        end else if (clear) begin
            row_idx <= '0;
        end else if (advance) begin
            if (row_idx == LAST_IDX) begin
                row_idx <= '0;
            end else begin
                row_idx <= row_idx + 1'b1;
            end
        end
    end

    assign last_row = (row_idx == LAST_IDX);

endmodule

`default_nettype wire

// ==== src/gemv_controller.sv ====
`default_nettype none

`include "gemv_settings.svh"

module gemv_controller (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    input  wire logic issue_last,
    input  wire logic retire_last,
    input  wire logic retire_strobe,
    output logic      issue_clear,
    output logic      issue_advance,
    output logic      retire_clear,
    output logic      mat_rd_en,
    output logic      busy,
    output logic      done
);

    import gemv_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        start_ok;

    // a start pulse outside IDLE is simply dropped.
    assign start_ok = start && (state_q == IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_ok) begin
                    state_d = ISSUE;
                end
            end
            ISSUE: begin
                // one row goes out per cycle, the eighth read ends the burst.
                if (issue_last) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (retire_strobe && retire_last) begin
                    state_d = FINISH;
                end
            end
            FINISH: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign issue_clear   = start_ok;
    assign retire_clear  = start_ok;
    assign mat_rd_en     = (state_q == ISSUE);
    assign issue_advance = (state_q == ISSUE);

    // busy covers issue, drain and the finish cycle itself.
    assign busy = (state_q != IDLE);
    assign done = (state_q == FINISH);

endmodule

`default_nettype wire

// ==== dot_product/dot_product_unit.sv ====
`default_nettype none

`include "gemv_settings.svh"

module dot_product_unit (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          vec_wr_en,
    input  gemv_data_pkg::row_t vec_wr_data,
    input  wire logic          in_valid,
    input  gemv_data_pkg::row_t in_row,
    output logic               out_valid,
    output gemv_data_pkg::acc_t out_sum
);

    import gemv_data_pkg::*;

    localparam int N = `GEMV_VEC_LEN;

    row_t  vec_q;
    prod_t prod_q [N];
    logic  prod_valid_q;

    // heap-ordered adder tree, leaves at N-1 .. 2N-2 and the root at index 0.
    acc_t  tree [2*N-1];
    acc_t  sum_q;

    always_ff @(posedge clk) begin
        if (vec_wr_en) begin
            vec_q <= vec_wr_data;
        end
    end

    // stage one registers all 32 signed products in parallel.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int i = 0; i < N; i++) begin
                prod_q[i] <= $signed(vec_q[i]) * $signed(in_row[i]);
            end
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_leaf
        // the size cast sign-extends each product to the full sum width.
        assign tree[N-1+i] = acc_t'(prod_q[i]);
    end

    for (genvar n = 0; n < N-1; n++) begin : g_node
        assign tree[n] = tree[2*n+1] + tree[2*n+2];
    end

    // stage two registers the root of the tree.
    always_ff @(posedge clk) begin
        if (prod_valid_q) begin
            sum_q <= tree[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid_q <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            prod_valid_q <= in_valid;
            out_valid    <= prod_valid_q;
        end
    end

    assign out_sum = sum_q;

endmodule

`default_nettype wire

// ==== src/gemv_top.sv ====
`default_nettype none

`include "gemv_settings.svh"

module gemv_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              start,
    output logic                   busy,
    output logic                   done,
    input  wire logic              vector_wr_en,
    input  gemv_data_pkg::row_t     vector_wr_data,
    input  wire logic              matrix_wr_en,
    input  gemv_ctrl_pkg::row_idx_t matrix_wr_row,
    input  gemv_data_pkg::row_t     matrix_wr_data,
    input  wire logic              res_rd_en,
    input  gemv_ctrl_pkg::row_idx_t res_rd_row,
    output gemv_data_pkg::acc_t     res_rd_data,
    output logic                   res_rd_valid
);

    import gemv_data_pkg::*;
    import gemv_ctrl_pkg::*;

    logic     issue_clear;
    logic     issue_advance;
    logic     issue_last;
    row_idx_t issue_idx;
    logic     retire_clear;
    logic     retire_last;
    row_idx_t retire_idx;
    logic     mat_rd_en;
    row_t     mat_rd_data;
    logic     mat_rd_valid;
    logic     dp_valid;
    acc_t     dp_sum;

    gemv_controller i_gemv_controller (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .issue_last    (issue_last),
        .retire_last   (retire_last),
        .retire_strobe (dp_valid),
        .issue_clear   (issue_clear),
        .issue_advance (issue_advance),
        .retire_clear  (retire_clear),
        .mat_rd_en     (mat_rd_en),
        .busy          (busy),
        .done          (done)
    );

    row_sequencer i_issue_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (issue_clear),
        .advance  (issue_advance),
        .row_idx  (issue_idx),
        .last_row (issue_last)
    );

    row_sequencer i_retire_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (retire_clear),
        .advance  (dp_valid),
        .row_idx  (retire_idx),
        .last_row (retire_last)
    );

    row_store #(
        .entry_t (row_t),
        .DEPTH   (`GEMV_ROWS)
    ) i_matrix_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (matrix_wr_en),
        .wr_addr  (matrix_wr_row),
        .wr_data  (matrix_wr_data),
        .rd_en    (mat_rd_en),
        .rd_addr  (issue_idx),
        .rd_data  (mat_rd_data),
        .rd_valid (mat_rd_valid)
    );

    dot_product_unit i_dot_product_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .vec_wr_en   (vector_wr_en),
        .vec_wr_data (vector_wr_data),
        .in_valid    (mat_rd_valid),
        .in_row      (mat_rd_data),
        .out_valid   (dp_valid),
        .out_sum     (dp_sum)
    );

    row_store #(
        .entry_t (acc_t),
        .DEPTH   (`GEMV_ROWS)
    ) i_result_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (dp_valid),
        .wr_addr  (retire_idx),
        .wr_data  (dp_sum),
        .rd_en    (res_rd_en),
        .rd_addr  (res_rd_row),
        .rd_data  (res_rd_data),
        .rd_valid (res_rd_valid)
    );

endmodule

`default_nettype wire

// ==== tb/gemv_tb.sv ====
`default_nettype none

`include "gemv_settings.svh"

module gemv_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import gemv_data_pkg::*;
    import gemv_ctrl_pkg::*;

    localparam int DONE_TIMEOUT = 50;
    localparam int READ_TIMEOUT = 10;
    localparam int IDLE_GAP     = 20;

    logic     clk;
    logic     rst_n;
    logic     start;
    logic     busy;
    logic     done;
    logic     vector_wr_en;
    row_t     vector_wr_data;
    logic     matrix_wr_en;
    row_idx_t matrix_wr_row;
    row_t     matrix_wr_data;
    logic     res_rd_en;
    row_idx_t res_rd_row;
    acc_t     res_rd_data;
    logic     res_rd_valid;

    row_t        ref_vec;
    row_t        ref_mat [`GEMV_ROWS];
    logic [31:0] lcg_state;
    acc_t        exp_q [$];
    int          row_q [$];
    acc_t        cmp_exp;
    int          cmp_row;
    int          done_pulses;
    int          run_count;
    int          mismatch_errors;
    int          other_errors;

    gemv_top i_gemv_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .busy           (busy),
        .done           (done),
        .vector_wr_en   (vector_wr_en),
        .vector_wr_data (vector_wr_data),
        .matrix_wr_en   (matrix_wr_en),
        .matrix_wr_row  (matrix_wr_row),
        .matrix_wr_data (matrix_wr_data),
        .res_rd_en      (res_rd_en),
        .res_rd_row     (res_rd_row),
        .res_rd_data    (res_rd_data),
        .res_rd_valid   (res_rd_valid)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic row_t rand_row();
        row_t r;
        for (int i = 0; i < `GEMV_VEC_LEN; i++) begin
            lcg_state = lcg_next(lcg_state);
            r[i] = elem_t'(lcg_state[23:18]);
        end
        return r;
    endfunction

    function automatic row_t pattern_row(input elem_t even_val, input elem_t odd_val);
        row_t r;
        for (int i = 0; i < `GEMV_VEC_LEN; i++) begin
            r[i] = (i % 2 == 0) ? even_val : odd_val;
        end
        return r;
    endfunction

    // sum of signed element products, kept at full integer width then cut to 17 bits.
    function automatic acc_t ref_dot(input row_t v, input row_t m);
        int sum;
        sum = 0;
        for (int i = 0; i < `GEMV_VEC_LEN; i++) begin
            sum = sum + int'(v[i]) * int'(m[i]);
        end
        return acc_t'(sum);
    endfunction

    task automatic load_vector(input row_t v);
        @(posedge clk);
        vector_wr_en   <= 1'b1;
        vector_wr_data <= v;
        @(posedge clk);
        vector_wr_en   <= 1'b0;
        ref_vec = v;
    endtask

    task automatic load_row(input int r, input row_t data);
        @(posedge clk);
        matrix_wr_en   <= 1'b1;
        matrix_wr_row  <= row_idx_t'(r);
        matrix_wr_data <= data;
        @(posedge clk);
        matrix_wr_en   <= 1'b0;
        ref_mat[r] = data;
    endtask

    task automatic run_engine(input bit extra_start);
        int waited;
        bit seen;
        run_count++;
        @(posedge clk);
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("busy or done high before start at %0t", $time);
            other_errors++;
        end
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        if (busy !== 1'b1) begin
            $display("busy did not rise in the cycle after start at %0t", $time);
            other_errors++;
        end
        if (extra_start) begin
            // this pulse lands in ISSUE and must be dropped.
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        waited = 0;
        seen   = 0;
        while (!seen && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            waited++;
            if (done === 1'b1) begin
                seen = 1;
            end else if (busy !== 1'b1) begin
                $display("busy went low before done at %0t", $time);
                other_errors++;
            end
        end
        if (!seen) begin
            $display("timed out waiting for done at %0t", $time);
            other_errors++;
        end else begin
            @(posedge clk);
            if (done !== 1'b0) begin
                $display("done stayed high for more than one cycle at %0t", $time);
                other_errors++;
            end
            if (busy !== 1'b0) begin
                $display("busy still high after done at %0t", $time);
                other_errors++;
            end
        end
        repeat (IDLE_GAP) @(posedge clk);
        if (done_pulses != run_count) begin
            $display("expected %0d done pulses so far, saw %0d", run_count, done_pulses);
            other_errors++;
        end
    endtask

    task automatic read_result(input int r, input acc_t expected);
        int waited;
        bit seen;
        exp_q.push_back(expected);
        row_q.push_back(r);
        @(posedge clk);
        res_rd_en  <= 1'b1;
        res_rd_row <= row_idx_t'(r);
        @(posedge clk);
        res_rd_en  <= 1'b0;
        waited = 0;
        seen   = 0;
        while (!seen && waited < READ_TIMEOUT) begin
            @(posedge clk);
            waited++;
            if (res_rd_valid === 1'b1) begin
                seen = 1;
            end
        end
        if (!seen) begin
            $display("timed out waiting for the result of row %0d at %0t", r, $time);
            other_errors++;
            exp_q.delete();
            row_q.delete();
        end
    endtask

    task automatic check_all_rows();
        for (int r = 0; r < `GEMV_ROWS; r++) begin
            read_result(r, ref_dot(ref_vec, ref_mat[r]));
        end
    endtask

    // compares each returned result with the oldest outstanding expectation.
    always @(posedge clk) begin
        if (rst_n && res_rd_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("result read strobe with no outstanding read at %0t", $time);
                other_errors++;
            end else begin
                cmp_exp = exp_q.pop_front();
                cmp_row = row_q.pop_front();
                if (res_rd_data !== cmp_exp) begin
                    $display("Mismatch at %0t: row %0d expected %0d actual %0d",
                             $time, cmp_row, cmp_exp, res_rd_data);
                    mismatch_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && done === 1'b1) begin
            done_pulses++;
        end
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        start           = 1'b0;
        vector_wr_en    = 1'b0;
        vector_wr_data  = '0;
        matrix_wr_en    = 1'b0;
        matrix_wr_row   = '0;
        matrix_wr_data  = '0;
        res_rd_en       = 1'b0;
        res_rd_row      = '0;
        lcg_state       = 32'h75c64a3c;
        done_pulses     = 0;
        run_count       = 0;
        mismatch_errors = 0;
        other_errors    = 0;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // nothing may happen before the first start.
        repeat (10) begin
            @(posedge clk);
            if (busy !== 1'b0 || done !== 1'b0) begin
                $display("busy or done not low after reset at %0t", $time);
                other_errors++;
            end
        end

        load_vector(rand_row());
        for (int r = 0; r < `GEMV_ROWS; r++) begin
            load_row(r, rand_row());
        end
        run_engine(1'b0);
        check_all_rows();

        // extreme values, the first three rows against fixed results.
        load_vector(pattern_row(-6'sd32, -6'sd32));
        load_row(0, pattern_row(-6'sd32, -6'sd32));
        load_row(1, pattern_row(6'sd31, 6'sd31));
        load_row(2, pattern_row(6'sd31, -6'sd31));
        for (int r = 3; r < `GEMV_ROWS; r++) begin
            load_row(r, rand_row());
        end
        run_engine(1'b0);
        read_result(0, 17'sd32768);
        read_result(1, -17'sd31744);
        read_result(2, 17'sd0);
        for (int r = 3; r < `GEMV_ROWS; r++) begin
            read_result(r, ref_dot(ref_vec, ref_mat[r]));
        end

        load_vector(rand_row());
        run_engine(1'b0);
        check_all_rows();

        load_vector(rand_row());
        run_engine(1'b1);
        check_all_rows();

        repeat (5) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/gemv_data_pkg.sv
common/gemv_ctrl_pkg.sv
src/row_store.sv
src/row_sequencer.sv
src/gemv_controller.sv
dot_product/dot_product_unit.sv
src/gemv_top.sv
tb/gemv_tb.sv
